// File: common/aguCmdPkg.sv
////////////////////
// micro-op codes and index extension fields
// size is carried to the response only, the stage never decodes it
////////////////////
`default_nettype none

package aguCmdPkg;

	// index widths taken by the two extension modes
	localparam int IxZxW = 32;
	localparam int IxSxW = 33;

	// scale and access size fields
	localparam int ScaleW = 2;
	localparam int SizeW = 2;

	// micro-op, one code left spare
	typedef enum logic [1:0]
	{
		OpLoad  = 2'b00,
		OpStore = 2'b01,
		OpLea   = 2'b10
	} aguOp_t;

	// index extension, 6 bits
	typedef struct packed
	{
		// index shift left by 0..3
		logic [ScaleW-1:0] scale;
		// 1 zero extends low 32 bits
		// 0 sign extends low 33 bits
		logic              zExt;
		// add imm as unsigned displacement
		logic              useDisp;
		// B/W/L/Q, passed through
		logic [SizeW-1:0]  size;
	} aguIxt_t;

endpackage

`default_nettype wire

// File: common/aguAddrPkg.sv
////////////////////
// address widths, bounds descriptor, request and response
// only the low 48 bits of base and index feed the address
////////////////////
`default_nettype none

package aguAddrPkg;

	import aguCmdPkg::*;

	// address and register widths
	localparam int AddrW = 48;
	localparam int RegW = 64;

	// adder segment width
	localparam int SegW = 16;

	// displacement and limit field widths
	localparam int ImmW = 16;
	localparam int LimW = 12;

	// index bits compared in 16-byte units, [31:4]
	localparam int BndLo = 4;
	localparam int BndHi = 32;
	localparam int BndW = BndHi - BndLo;

	// fault log counter
	localparam int FaultCntW = 16;

	// bounds descriptor, 30 bits
	typedef struct packed
	{
		logic            checkEn;
		logic            forceFault;
		// stores to this region fault
		logic            isConst;
		// limits times 16**limShift
		logic [1:0]      limShift;
		// limits times 4 first
		logic            fine;
		logic [LimW-1:0] upLim;
		logic [LimW-1:0] dnLim;
	} aguBound_t;

	typedef struct packed
	{
		logic [RegW-1:0] base;
		logic [RegW-1:0] index;
		logic [ImmW-1:0] imm;
		aguOp_t          op;
		aguIxt_t         ixt;
		// keep top 16 address bits
		logic            wide;
		aguBound_t       bound;
	} aguReq_t;

	typedef struct packed
	{
		logic [AddrW-1:0] addr;
		logic             oob;
		aguOp_t           op;
		logic [SizeW-1:0] size;
	} aguResp_t;

endpackage

`default_nettype wire

// File: hw/agu/ExAguAdd.sv
////////////////////
// combinational, sum wraps modulo 2**48
// top segment reads zero unless wide is set
////////////////////
`timescale 1ns/1ps
`default_nettype none

module ExAguAdd
	import aguAddrPkg::*;
(
	input  wire [AddrW-1:0] base,
	input  wire [AddrW-1:0] index,
	input  wire [ImmW-1:0]  disp,
	input  wire             wide,
	output logic [AddrW-1:0] sum
);

	// low segment plus its two-bit carry
	logic [SegW+1:0] loSum;

	// middle candidates, carry-in 0/1/2
	logic [SegW+1:0] midC0;
	logic [SegW+1:0] midC1;
	logic [SegW+1:0] midC2;
	logic [SegW+1:0] midSel;

	// upper candidates, no carry out kept
	logic [SegW-1:0] hiC0;
	logic [SegW-1:0] hiC1;
	logic [SegW-1:0] hiC2;
	logic [SegW-1:0] hiSel;

	always_comb
	begin
		// three inputs meet only in the low segment
		loSum = {2'b00, base[SegW-1:0]} + {2'b00, index[SegW-1:0]} + {2'b00, disp};

		// carry-in can reach 2 with the displacement
		midC0 = {2'b00, base[2*SegW-1:SegW]} + {2'b00, index[2*SegW-1:SegW]};
		midC1 = {2'b00, base[2*SegW-1:SegW]} + {2'b00, index[2*SegW-1:SegW]} + (SegW+2)'(1);
		midC2 = {2'b00, base[2*SegW-1:SegW]} + {2'b00, index[2*SegW-1:SegW]} + (SegW+2)'(2);

		hiC0 = base[AddrW-1:2*SegW] + index[AddrW-1:2*SegW];
		hiC1 = base[AddrW-1:2*SegW] + index[AddrW-1:2*SegW] + SegW'(1);
		hiC2 = base[AddrW-1:2*SegW] + index[AddrW-1:2*SegW] + SegW'(2);

		// select middle by low carry
		case (loSum[SegW+1:SegW])
			2'd0:    midSel = midC0;
			2'd1:    midSel = midC1;
			default: midSel = midC2;
		endcase

		// select upper by middle carry
		case (midSel[SegW+1:SegW])
			2'd0:    hiSel = hiC0;
			2'd1:    hiSel = hiC1;
			default: hiSel = hiC2;
		endcase

		// narrow mode drops the top segment
		if (!wide)
		begin
			hiSel = '0;
		end

		sum = {hiSel, midSel[SegW-1:0], loSum[SegW-1:0]};
	end

endmodule

`default_nettype wire

// File: hw/agu/ExAguBound.sv
////////////////////
// combinational bounds check on the scaled index
// limits are in 16-byte units, oob is 0 when checkEn is clear
////////////////////
`timescale 1ns/1ps
`default_nettype none

module ExAguBound
	import aguCmdPkg::*;
	import aguAddrPkg::*;
(
	input  wire [AddrW-1:0] index,
	input  wire aguBound_t  bound,
	input  wire aguOp_t     op,
	output logic            oob
);

	// limits before and after scaling
	logic [BndW-1:0] upBase;
	logic [BndW-1:0] dnBase;
	logic [BndW-1:0] upLimit;
	logic [BndW-1:0] dnScaled;
	logic [BndW-1:0] dnLimit;

	// range sum, carry out is the overflow
	logic [LimW:0] limSum;

	// index split for the compares
	logic                   idxNeg;
	logic [AddrW-BndHi-1:0] idxTop;
	logic [BndW-1:0]        idxUnits;

	// individual fault terms
	logic posOob;
	logic negOob;
	logic rangeOvf;
	logic constFault;

	always_comb
	begin
		idxNeg = index[AddrW-1];
		idxTop = index[AddrW-1:BndHi];
		idxUnits = index[BndHi-1:BndLo];

		// fine granularity scales both limits by 4
		if (bound.fine)
		begin
			upBase = {{(BndW-LimW-2){1'b0}}, bound.upLim, 2'b00};
			dnBase = {{(BndW-LimW-2){1'b0}}, bound.dnLim, 2'b00};
		end
		else
		begin
			upBase = {{(BndW-LimW){1'b0}}, bound.upLim};
			dnBase = {{(BndW-LimW){1'b0}}, bound.dnLim};
		end

		// 4 bits of shift per limShift step
		upLimit = upBase << {bound.limShift, 2'b00};
		dnScaled = dnBase << {bound.limShift, 2'b00};

		// negative side compares against one's complement
		dnLimit = ~dnScaled;

		// upper bits must be a pure extension of the sign
		posOob = (idxTop != '0) || (idxUnits >= upLimit);
		negOob = (idxTop != '1) || (idxUnits <= dnLimit);

		// limits that together exceed the 12-bit range
		limSum = {1'b0, bound.upLim} + {1'b0, bound.dnLim};
		rangeOvf = limSum[LimW];

		// write to a constant region
		constFault = bound.isConst && (op == OpStore);

		oob = bound.checkEn &&
			((idxNeg ? negOob : posOob) || rangeOvf || constFault || bound.forceFault);
	end

endmodule

`default_nettype wire

// File: hw/agu/ExAgu.sv
////////////////////
// one cycle deep, a strobe at one edge shows after the next
// no back-pressure, one request may issue every cycle
////////////////////
`timescale 1ns/1ps
`default_nettype none

module ExAgu
	import aguCmdPkg::*;
	import aguAddrPkg::*;
(
	input  wire          clock,
	input  wire          rstN,
	input  wire          reqValid,
	input  wire aguReq_t req,
	output logic         respValid,
	output aguResp_t     resp
);

	// extended and scaled index
	logic [AddrW-1:0] idxExt;
	logic [AddrW-1:0] idxScaled;

	// displacement, zero when unused
	logic [ImmW-1:0] disp;

	// combinational results
	logic [AddrW-1:0] addrSum;
	logic             addrOob;

	always_comb
	begin
		// zero extend 32 bits or sign extend 33 bits
		if (req.ixt.zExt)
		begin
			idxExt = {{(AddrW-IxZxW){1'b0}}, req.index[IxZxW-1:0]};
		end
		else
		begin
			idxExt = {{(AddrW-IxSxW){req.index[IxSxW-1]}}, req.index[IxSxW-1:0]};
		end

		// element scale B/W/L/Q
		idxScaled = idxExt << req.ixt.scale;

		disp = req.ixt.useDisp ? req.imm : '0;
	end

	// base + scaled index + displacement
	ExAguAdd ExAguAdd_i
	(
		.base  (req.base[AddrW-1:0]),
		.index (idxScaled),
		.disp  (disp),
		.wide  (req.wide),
		.sum   (addrSum)
	);

	// bounds check sees the scaled index, not the sum
	ExAguBound ExAguBound_i
	(
		.index (idxScaled),
		.bound (req.bound),
		.op    (req.op),
		.oob   (addrOob)
	);

	// valid strobe
	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			respValid <= 1'b0;
		end
		else
		begin
			respValid <= reqValid;
		end
	end

	// payload, loaded only on an issue
	always_ff @(posedge clock)
	begin
		if (reqValid)
		begin
			resp.addr <= addrSum;
			resp.oob <= addrOob;
			resp.op <= req.op;
			resp.size <= req.ixt.size;
		end
	end

endmodule

`default_nettype wire

// File: hw/AguFaultLog.sv
////////////////////
// count saturates, first address held until faultClr
// a fault in the clear cycle wins, the clear is dropped
////////////////////
`timescale 1ns/1ps
`default_nettype none

module AguFaultLog
	import aguAddrPkg::*;
(
	input  wire                  clock,
	input  wire                  rstN,
	input  wire                  respValid,
	input  wire aguResp_t        resp,
	input  wire                  faultClr,
	output logic [FaultCntW-1:0] faultCount,
	output logic                 faultSeen,
	output logic [AddrW-1:0]     faultAddr
);

	// valid response flagged out of bounds
	logic faultHit;

	assign faultHit = respValid && resp.oob;

	// counter and first-fault flag
	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			faultCount <= '0;
			faultSeen <= 1'b0;
		end
		else if (faultHit)
		begin
			// hold at all ones
			if (faultCount != '1)
			begin
				faultCount <= faultCount + FaultCntW'(1);
			end
			faultSeen <= 1'b1;
		end
		else if (faultClr)
		begin
			faultCount <= '0;
			faultSeen <= 1'b0;
		end
	end

	// capture only while no fault is logged
	always_ff @(posedge clock)
	begin
		if (faultHit && !faultSeen)
		begin
			faultAddr <= resp.addr;
		end
	end

endmodule

`default_nettype wire

// File: hw/AguStage.sv
////////////////////
// address stage top, one cycle request to response
// fault log lags the response by one more cycle
////////////////////
`timescale 1ns/1ps
`default_nettype none

module AguStage
	import aguAddrPkg::*;
(
	input  wire                 clock,
	input  wire                 rstN,
	input  wire                 reqValid,
	input  wire aguReq_t        req,
	input  wire                 faultClr,
	output wire                 respValid,
	output wire aguResp_t       resp,
	output wire [FaultCntW-1:0] faultCount,
	output wire                 faultSeen,
	output wire [AddrW-1:0]     faultAddr
);

	// address, bounds and output register
	ExAgu ExAgu_i
	(
		.clock     (clock),
		.rstN      (rstN),
		.reqValid  (reqValid),
		.req       (req),
		.respValid (respValid),
		.resp      (resp)
	);

	// watches the registered response
	AguFaultLog AguFaultLog_i
	(
		.clock      (clock),
		.rstN       (rstN),
		.respValid  (respValid),
		.resp       (resp),
		.faultClr   (faultClr),
		.faultCount (faultCount),
		.faultSeen  (faultSeen),
		.faultAddr  (faultAddr)
	);

endmodule

`default_nettype wire

// File: verif/tbAguStage.sv
////////////////////
// reads verif/aguStim.txt, run from the project root
// random gaps in the first half of the lines, back-to-back after
////////////////////
`timescale 1ns/1ps
`default_nettype none

module tbAguStage
	import aguCmdPkg::*;
	import aguAddrPkg::*;
();

	// one stimulus line and its expected result
	typedef struct packed
	{
		aguReq_t          req;
		logic [AddrW-1:0] expAddr;
		logic             expOob;
	} stimLine_t;

	// response owed for one issue
	typedef struct packed
	{
		logic [AddrW-1:0] addr;
		logic             oob;
		aguOp_t           op;
		logic [SizeW-1:0] size;
		logic [31:0]      dueCycle;
	} expResp_t;

	logic                 clock;
	logic                 rstN;
	logic                 reqValid;
	aguReq_t              req;
	logic                 faultClr;
	wire                  respValid;
	aguResp_t             resp;
	wire [FaultCntW-1:0]  faultCount;
	wire                  faultSeen;
	wire [AddrW-1:0]      faultAddr;

	stimLine_t stimQ[$];
	expResp_t  expQ[$];

	// counters, updated with NBA so readers see stable values
	int cycleCount = 0;
	int respCount = 0;
	int cycleLimit = 0;

	AguStage AguStage_i
	(
		.clock      (clock),
		.rstN       (rstN),
		.reqValid   (reqValid),
		.req        (req),
		.faultClr   (faultClr),
		.respValid  (respValid),
		.resp       (resp),
		.faultCount (faultCount),
		.faultSeen  (faultSeen),
		.faultAddr  (faultAddr)
	);

	// 4 ns period
	always #2 clock = ~clock;

	task automatic checkValue(input string what, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp)
		begin
			$display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			$display("Test failed");
			$fatal(1, "mismatch on %s", what);
		end
	endtask

	task automatic readStim();
		int fd;
		int code;
		int n;
		string line;
		logic [RegW-1:0] base;
		logic [RegW-1:0] index;
		logic [ImmW-1:0] imm;
		logic [1:0] op;
		logic [5:0] ixt;
		logic wide;
		logic [29:0] bound;
		logic [AddrW-1:0] expAddr;
		logic expOob;
		stimLine_t s;
		fd = $fopen("verif/aguStim.txt", "r");
		if (fd == 0)
		begin
			$display("Test failed");
			$fatal(1, "could not open the stimulus file verif/aguStim.txt");
		end
		while (!$feof(fd))
		begin
			code = $fgets(line, fd);
			// comment and blank lines
			if (code <= 0 || line.getc(0) == "#")
			begin
				continue;
			end
			n = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
				base, index, imm, op, ixt, wide, bound, expAddr, expOob);
			if (n > 0 && n != 9)
			begin
				$display("Test failed");
				$fatal(1, "stimulus line has %0d fields instead of 9", n);
			end
			if (n == 9)
			begin
				s.req.base = base;
				s.req.index = index;
				s.req.imm = imm;
				s.req.op = aguOp_t'(op);
				s.req.ixt = ixt;
				s.req.wide = wide;
				s.req.bound = bound;
				s.expAddr = expAddr;
				s.expOob = expOob;
				stimQ.push_back(s);
			end
		end
		$fclose(fd);
	endtask

	// timeout and response checker
	always @(posedge clock)
	begin
		expResp_t head;
		cycleCount <= cycleCount + 1;
		if (cycleLimit != 0 && cycleCount >= cycleLimit)
		begin
			$display("Test failed");
			$fatal(1, "run timed out after %0d cycles", cycleCount);
		end
		else if (rstN && respValid)
		begin
			if (expQ.size() == 0)
			begin
				$display("Test failed");
				$fatal(1, "a response arrived with no request outstanding");
			end
			else
			begin
				head = expQ.pop_front();
				// one cycle after the request registers
				checkValue("response cycle", 64'(cycleCount), 64'(head.dueCycle));
				checkValue("addr", 64'(resp.addr), 64'(head.addr));
				checkValue("oob", 64'(resp.oob), 64'(head.oob));
				checkValue("op", 64'(resp.op), 64'(head.op));
				checkValue("size", 64'(resp.size), 64'(head.size));
				respCount <= respCount + 1;
			end
		end
	end

	initial
	begin
		int i;
		int gap;
		int oobCount;
		logic [AddrW-1:0] firstFaultAddr;
		stimLine_t s;
		expResp_t e;
		clock = 1'b0;
		rstN <= 1'b0;
		reqValid <= 1'b0;
		req <= '0;
		faultClr <= 1'b0;
		void'($urandom(57419));
		readStim();
		cycleLimit = stimQ.size() * 4 + 50;

		// expected fault log contents
		oobCount = 0;
		firstFaultAddr = '0;
		for (i = 0; i < stimQ.size(); i++)
		begin
			if (stimQ[i].expOob)
			begin
				if (oobCount == 0)
				begin
					firstFaultAddr = stimQ[i].expAddr;
				end
				oobCount++;
			end
		end

		repeat (5) @(posedge clock);
		rstN <= 1'b1;
		@(posedge clock);
		checkValue("respValid after reset", 64'(respValid), 64'(0));
		checkValue("faultCount after reset", 64'(faultCount), 64'(0));
		checkValue("faultSeen after reset", 64'(faultSeen), 64'(0));

		for (i = 0; i < stimQ.size(); i++)
		begin
			s = stimQ[i];
			reqValid <= 1'b1;
			req <= s.req;
			e.addr = s.expAddr;
			e.oob = s.expOob;
			e.op = s.req.op;
			e.size = s.req.ixt.size;
			e.dueCycle = 32'(cycleCount + 2);
			expQ.push_back(e);
			@(posedge clock);
			gap = (i < stimQ.size() / 2) ? int'($urandom % 3) : 0;
			repeat (gap)
			begin
				reqValid <= 1'b0;
				@(posedge clock);
			end
		end
		reqValid <= 1'b0;

		// drain, the log settles one cycle after the last response
		while (respCount < stimQ.size())
		begin
			@(posedge clock);
		end
		checkValue("faultCount", 64'(faultCount), 64'(oobCount));
		checkValue("faultSeen", 64'(faultSeen), 64'(oobCount != 0));
		if (oobCount != 0)
		begin
			checkValue("faultAddr", 64'(faultAddr), 64'(firstFaultAddr));
		end

		// clear pulse, visible two edges on
		faultClr <= 1'b1;
		@(posedge clock);
		faultClr <= 1'b0;
		@(posedge clock);
		checkValue("faultCount after clear", 64'(faultCount), 64'(0));
		checkValue("faultSeen after clear", 64'(faultSeen), 64'(0));

		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verif/aguStim.txt
# base index imm op ixt wide bound expAddr expOob, all hex
# ixt={scale,zExt,useDisp,size} bound={checkEn,forceFault,isConst,limShift,fine,upLim,dnLim}
0000000000001000 0000000000000010 0004 0 1d 1 00000000 000000001024 0
0000000000100000 fffffffffffffff0 0000 0 22 1 00000000 0000000fffc0 0
0000000000020000 0000000000000100 0010 1 37 1 00000000 000000020810 0
0000000000000000 0000000180000000 0000 0 08 1 00000000 000080000000 0
0000000000000000 0000000180000000 0000 0 00 1 00000000 ffff80000000 0
0000000000000000 0000000180000000 0000 0 00 0 00000000 000080000000 0
0000000000000100 deadbeef00000001 ffff 2 2c 1 00000000 000000010103 0
000000000000ffff 0000000000000001 ffff 0 0c 1 00000000 00000001ffff 0
000000000000ffff 000000000000ffff ffff 0 0c 1 00000000 00000002fffd 0
00000000ffffffff 0000000000000001 0000 0 08 1 00000000 000100000000 0
00000000ffffffff 0000000000000001 0000 0 08 0 00000000 000000000000 0
0000000100000000 ffffffffffffffff 0000 0 00 1 00000000 0000ffffffff 0
abcdfffffffffff0 0000000000000020 0000 0 08 1 00000000 000000000010 0
00001234ffffffff 000000000000ffff ffff 0 0c 1 00000000 12350001fffd 0
0000000000000000 00000000000000f0 0000 0 08 1 20010008 0000000000f0 0
0000000000000000 0000000000000100 0000 0 08 1 20010008 000000000100 1
0000000000000000 ffffffffffffff80 0000 0 00 1 20010008 ffffffffff80 0
0000000000000000 ffffffffffffff70 0000 0 00 1 20010008 ffffffffff70 1
0000000000000000 0000000020000000 0000 0 38 1 20010008 000100000000 1
0000000000000000 0000000000000ff0 0000 0 08 1 23004002 000000000ff0 0
0000000000000000 0000000000001000 0000 0 08 1 23004002 000000001000 1
0000000000000000 fffffffffffff800 0000 0 00 1 23004002 fffffffff800 0
0000000000000000 fffffffffffff7ff 0000 0 00 1 23004002 fffffffff7ff 1
0000000000000000 000000000000ffff 0000 0 08 1 26001001 00000000ffff 0
0000000000000000 0000000000010000 0000 0 08 1 26001001 000000010000 1
0000000000000000 ffffffffffff0000 0000 0 00 1 26001001 ffffffff0000 0
0000000000000000 fffffffffffeffff 0000 0 00 1 26001001 fffffffeffff 1
0000000000000000 0000000000004000 0000 0 08 1 25001001 000000004000 1
0000000000000000 0000000000004000 0000 0 08 1 05001001 000000004000 0
0000000000000000 0000000000000010 0000 1 08 1 28010008 000000000010 1
0000000000000000 0000000000000010 0000 0 08 1 28010008 000000000010 0
0000000000000000 0000000000000010 0000 2 08 1 30010008 000000000010 1
0000000000000000 0000000000000010 0000 0 08 1 20800800 000000000010 1
0000000000000000 0000000000000010 0000 0 08 1 208007ff 000000000010 0

// File: src.f
common/aguCmdPkg.sv
common/aguAddrPkg.sv
hw/agu/ExAguAdd.sv
hw/agu/ExAguBound.sv
hw/agu/ExAgu.sv
hw/AguFaultLog.sv
hw/AguStage.sv
verif/tbAguStage.sv

// File: run.sh
#!/bin/sh
# Build and run the address stage testbench with Verilator.
# The exit status is the simulator's: 0 on pass, non-zero on any failure.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tbAguStage -f src.f --Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

./obj_dir/VtbAguStage
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi

exit 0
